/* include/rv32_opcodes.svh */
`ifndef RV32_OPCODES_SVH
`define RV32_OPCODES_SVH

// major opcodes of the base integer set.
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

// funct3 of the arithmetic and logic group.
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 of the conditional branches.
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000 // selects sub and sra.

`endif

/* source/rv32_pkg.sv */
package rv32_pkg;

    `include "rv32_opcodes.svh"

    localparam int xlen = 32; // fixed by the ISA.

    // alu operation codes. pass_b sits at all ones, which is what lui uses.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'b1111
    } alu_op_e;

    // decoded instruction as it waits in the issue register.
    typedef struct packed {
        alu_op_e         alu_op;
        logic [xlen-1:0] operand_a;
        logic [xlen-1:0] operand_b;
        logic [xlen-1:0] rs1_value; // raw sources, the branch compare needs them.
        logic [xlen-1:0] rs2_value;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic            reg_write;
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        logic            is_mem;
        logic            illegal;
    } ex_issue_t;

    // outcome of execute, as held in the result register.
    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] addr_sum; // load and store address.
        logic            branch_taken;
        logic [xlen-1:0] branch_target;
        logic [4:0]      rd;
        logic            reg_write;
        logic            is_mem;
        logic            illegal;
    } ex_result_t;

endpackage

/* source/alu_decoder.sv */
`timescale 1ns/100ps

module alu_decoder
    import rv32_pkg::*;
(
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    output ex_issue_t       issue
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    // maps funct3 onto an operation, alt picks sub or sra.
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD_SUB: arith_op = alt ? alu_sub : alu_add;
            `F3_SLL:     arith_op = alu_sll;
            `F3_SLT:     arith_op = alu_slt;
            `F3_SLTU:    arith_op = alu_sltu;
            `F3_XOR:     arith_op = alu_xor;
            `F3_SR:      arith_op = alt ? alu_sra : alu_srl;
            `F3_OR:      arith_op = alu_or;
            default:     arith_op = alu_and; // the only code left is and.
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // all immediates are sign extended from bit 31.
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        issue           = '0;
        issue.alu_op    = alu_add;
        issue.operand_a = rs1_value;
        issue.operand_b = rs2_value;
        issue.rs1_value = rs1_value;
        issue.rs2_value = rs2_value;
        issue.pc        = pc;
        issue.rd        = instr[11:7];
        issue.funct3    = funct3;

        case (opcode)
            `OPC_OP: begin
                issue.reg_write = 1'b1;
                issue.alu_op    = arith_op(funct3, funct7[5]);
                // the alternate funct7 is only defined for sub and sra.
                if (funct7 != `F7_BASE &&
                    !(funct7 == `F7_ALT && (funct3 == `F3_ADD_SUB || funct3 == `F3_SR)))
                    issue.illegal = 1'b1;
            end
            `OPC_OP_IMM: begin
                issue.reg_write = 1'b1;
                issue.imm       = imm_i;
                issue.operand_b = imm_i;
                issue.alu_op    = arith_op(funct3, funct7[5] && funct3 == `F3_SR);
                if (funct3 == `F3_SLL && funct7 != `F7_BASE)
                    issue.illegal = 1'b1;
                if (funct3 == `F3_SR && funct7 != `F7_BASE && funct7 != `F7_ALT)
                    issue.illegal = 1'b1;
            end
            `OPC_LOAD: begin
                issue.reg_write = 1'b1;
                issue.is_mem    = 1'b1;
                issue.imm       = imm_i;
                issue.operand_b = imm_i;
            end
            `OPC_STORE: begin
                issue.is_mem    = 1'b1;
                issue.imm       = imm_s;
                issue.operand_b = imm_s;
            end
            `OPC_LUI: begin
                issue.reg_write = 1'b1;
                issue.imm       = imm_u;
                issue.operand_b = imm_u;
                issue.alu_op    = alu_pass_b;
            end
            `OPC_AUIPC: begin
                issue.reg_write = 1'b1;
                issue.imm       = imm_u;
                issue.operand_a = pc;
                issue.operand_b = imm_u;
            end
            `OPC_BRANCH: begin
                issue.is_branch = 1'b1; // compare happens in the branch unit.
                issue.imm       = imm_b;
            end
            `OPC_JAL: begin
                issue.reg_write = 1'b1;
                issue.is_jal    = 1'b1;
                issue.imm       = imm_j;
                issue.operand_a = pc;
                issue.operand_b = xlen'(4); // link value is pc + 4.
            end
            `OPC_JALR: begin
                issue.reg_write = 1'b1;
                issue.is_jalr   = 1'b1;
                issue.imm       = imm_i;
                issue.operand_a = pc;
                issue.operand_b = xlen'(4);
            end
            default: issue.illegal = 1'b1;
        endcase

        // an illegal instruction must never write the register file.
        if (issue.illegal)
            issue.reg_write = 1'b0;
    end

endmodule

/* source/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    input  payload_t data_in,
    input  logic     stall,
    input  logic     flush,
    output logic     valid_out,
    output payload_t data_out
);

    // stall wins over flush, so a held entry survives a flush.
    always_ff @(posedge clk) begin
        if (reset)
            valid_out <= 1'b0;
        else if (!stall)
            valid_out <= valid_in && !flush;
    end

    // payload only loads with a valid entry.
    always_ff @(posedge clk) begin
        if (!stall && valid_in)
            data_out <= data_in;
    end

    // the valid bit feeds the next stage and the outside world,
    // an unknown here would spread through the whole pipeline.
    valid_known_a: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(valid_out))
        else $error("pipe_reg valid_out is unknown");

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu
    import rv32_pkg::*;
(
    input  logic [xlen-1:0] operand_a,
    input  logic [xlen-1:0] operand_b,
    input  alu_op_e         alu_op,
    output logic [xlen-1:0] result,
    output logic [xlen-1:0] addr_sum
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = operand_b[4:0]; // only the low five bits shift.
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    // the sum is always available, loads and stores take it as address.
    assign addr_sum = operand_a + operand_b;

    always_comb begin
        case (alu_op)
            alu_add:    result = addr_sum;
            alu_sub:    result = operand_a - operand_b;
            alu_sll:    result = operand_a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    result = operand_a ^ operand_b;
            alu_srl:    result = operand_a >> shamt;
            alu_sra:    result = $signed(operand_a) >>> shamt; // keeps the sign bit.
            alu_or:     result = operand_a | operand_b;
            alu_and:    result = operand_a & operand_b;
            alu_pass_b: result = operand_b;
            default:    result = '0;
        endcase
    end

    // the decoder should only ever hand over a named operation.
    // an issue register that was never loaded may still hold unknowns.
    always_comb begin
        assert final ($isunknown(alu_op) ||
                      alu_op inside {alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                     alu_xor, alu_srl, alu_sra, alu_or, alu_and,
                                     alu_pass_b})
            else $error("alu received undefined operation %0h", alu_op);
    end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit
    import rv32_pkg::*;
(
    input  ex_issue_t       issue,
    output logic            branch_taken,
    output logic [xlen-1:0] branch_target
);

    logic            condition;
    logic [xlen-1:0] jalr_sum;

    always_comb begin
        case (issue.funct3)
            `F3_BEQ:  condition = issue.rs1_value == issue.rs2_value;
            `F3_BNE:  condition = issue.rs1_value != issue.rs2_value;
            `F3_BLT:  condition = $signed(issue.rs1_value) < $signed(issue.rs2_value);
            `F3_BGE:  condition = $signed(issue.rs1_value) >= $signed(issue.rs2_value);
            `F3_BLTU: condition = issue.rs1_value < issue.rs2_value;
            `F3_BGEU: condition = issue.rs1_value >= issue.rs2_value;
            default:  condition = 1'b0; // 010 and 011 are not branches.
        endcase
    end

    assign jalr_sum = issue.rs1_value + issue.imm;

    // jumps are always taken.
    assign branch_taken = (issue.is_branch && condition) || issue.is_jal || issue.is_jalr;

    // jalr clears bit 0 of its target.
    assign branch_target = issue.is_jalr ? {jalr_sum[xlen-1:1], 1'b0} : issue.pc + issue.imm;

    // a taken branch needs exactly one control flag from the decoder.
    always_comb begin
        assert final ($isunknown({issue.is_branch, issue.is_jal, issue.is_jalr}) ||
                      !branch_taken ||
                      $onehot({issue.is_branch, issue.is_jal, issue.is_jalr}))
            else $error("branch taken without a single control flag");
    end

endmodule

/* source/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit
    import rv32_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_value,
    input  logic [xlen-1:0] rs2_value,
    input  logic            stall,
    input  logic            flush,
    output logic            out_valid,
    output ex_result_t      out
);

    ex_issue_t       issue_d;
    ex_issue_t       issue_q;
    logic            issue_valid;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] addr_sum;
    logic            branch_taken;
    logic [xlen-1:0] branch_target;
    ex_result_t      result_d;

    alu_decoder u_decoder (
        .instr     (instr),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .issue     (issue_d)
    );

    // first stage, holds the decoded instruction.
    pipe_reg #(.payload_t(ex_issue_t)) u_issue_reg (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (in_valid),
        .data_in   (issue_d),
        .stall     (stall),
        .flush     (flush),
        .valid_out (issue_valid),
        .data_out  (issue_q)
    );

    alu u_alu (
        .operand_a (issue_q.operand_a),
        .operand_b (issue_q.operand_b),
        .alu_op    (issue_q.alu_op),
        .result    (alu_result),
        .addr_sum  (addr_sum)
    );

    branch_unit u_branch (
        .issue         (issue_q),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    assign result_d = '{
        result:        alu_result,
        addr_sum:      addr_sum,
        branch_taken:  branch_taken,
        branch_target: branch_target,
        rd:            issue_q.rd,
        reg_write:     issue_q.reg_write,
        is_mem:        issue_q.is_mem,
        illegal:       issue_q.illegal
    };

    // second stage. the instruction already in execute completes on a flush.
    pipe_reg #(.payload_t(ex_result_t)) u_result_reg (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (issue_valid),
        .data_in   (result_d),
        .stall     (stall),
        .flush     (1'b0),
        .valid_out (out_valid),
        .data_out  (out)
    );

endmodule

/* verification/exec_unit_tb.sv */
`timescale 1ns/100ps

module exec_unit_tb
    import rv32_pkg::*;
();

    localparam int num_cycles  = 3000;
    localparam int cycle_limit = 2 * num_cycles + 20;

    // one slot of the model pipeline, care marks the bits the ISA defines.
    typedef struct packed {
        logic       valid;
        ex_result_t expected;
        ex_result_t care;
    } stage_t;

    logic            clk;
    logic            reset;
    logic            in_valid;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic            stall;
    logic            flush;
    logic            out_valid;
    ex_result_t      out;

    logic [31:0] rng_state = 32'd84588;
    stage_t      pipe_q[$]; // index 0 is the issue stage, index 1 the result stage.
    int          value_errors = 0;
    int          valid_errors = 0;
    int          checks = 0;
    int          cycle_count = 0;

    exec_unit dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .stall     (stall),
        .flush     (flush),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // integer operations as the ISA defines them, selected by funct3.
    function automatic logic [31:0] alu_reference(input logic [2:0] f3, input logic alt,
                                                  input logic [31:0] x, input logic [31:0] y);
        logic [4:0] sh;
        sh = y[4:0];
        case (f3)
            `F3_ADD_SUB: begin
                if (alt)
                    return x - y;
                return x + y;
            end
            `F3_SLL:  return x << sh;
            `F3_SLT:  return {31'b0, $signed(x) < $signed(y)};
            `F3_SLTU: return {31'b0, x < y};
            `F3_XOR:  return x ^ y;
            `F3_SR: begin
                if (alt)
                    return $signed(x) >>> sh;
                return x >> sh;
            end
            `F3_OR:   return x | y;
            default:  return x & y;
        endcase
    endfunction

    function automatic logic branch_reference(input logic [2:0] f3,
                                              input logic [31:0] x, input logic [31:0] y);
        case (f3)
            `F3_BEQ:  return x == y;
            `F3_BNE:  return x != y;
            `F3_BLT:  return $signed(x) < $signed(y);
            `F3_BGE:  return $signed(x) >= $signed(y);
            `F3_BLTU: return x < y;
            default:  return x >= y;
        endcase
    endfunction

    function automatic void predict_result(input logic [31:0] ins, input logic [31:0] pc_v,
                                           input logic [31:0] a, input logic [31:0] b,
                                           output ex_result_t exp, output ex_result_t care);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        f3    = ins[14:12];
        f7    = ins[31:25];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        exp               = '0;
        care              = '0;
        exp.rd            = ins[11:7];
        care.rd           = '1;
        care.reg_write    = 1'b1;
        care.is_mem       = 1'b1;
        care.illegal      = 1'b1;
        care.branch_taken = 1'b1; // only control flow may ever be taken.
        case (ins[6:0])
            `OPC_OP: begin
                exp.illegal = !(f7 == `F7_BASE ||
                                (f7 == `F7_ALT && (f3 == `F3_ADD_SUB || f3 == `F3_SR)));
                exp.result  = alu_reference(f3, f7 == `F7_ALT, a, b);
                care.result = exp.illegal ? '0 : '1;
            end
            `OPC_OP_IMM: begin
                exp.illegal = (f3 == `F3_SLL && f7 != `F7_BASE) ||
                              (f3 == `F3_SR && f7 != `F7_BASE && f7 != `F7_ALT);
                exp.result  = alu_reference(f3, f3 == `F3_SR && f7 == `F7_ALT, a, imm_i);
                care.result = exp.illegal ? '0 : '1;
            end
            `OPC_LOAD: begin
                exp.is_mem    = 1'b1;
                exp.addr_sum  = a + imm_i;
                care.addr_sum = '1;
            end
            `OPC_STORE: begin
                exp.is_mem    = 1'b1;
                exp.addr_sum  = a + imm_s;
                care.addr_sum = '1;
            end
            `OPC_LUI: begin
                exp.result  = imm_u;
                care.result = '1;
            end
            `OPC_AUIPC: begin
                exp.result  = pc_v + imm_u;
                care.result = '1;
            end
            `OPC_BRANCH: begin
                exp.branch_taken   = branch_reference(f3, a, b);
                exp.branch_target  = pc_v + imm_b;
                care.branch_target = '1;
            end
            `OPC_JAL, `OPC_JALR: begin
                exp.branch_taken   = 1'b1;
                exp.result         = pc_v + 32'd4; // link address.
                care.result        = '1;
                exp.branch_target  = (ins[6:0] == `OPC_JAL) ? pc_v + imm_j
                                                            : (a + imm_i) & ~32'd1;
                care.branch_target = '1;
            end
            default: exp.illegal = 1'b1;
        endcase
        // stores and branches have no destination, illegal ones write nothing.
        exp.reg_write = !exp.illegal && ins[6:0] != `OPC_STORE && ins[6:0] != `OPC_BRANCH;
    endfunction

    function logic [31:0] make_instruction();
        logic [31:0] ins;
        logic [31:0] r;
        logic [3:0]  kind;
        ins  = next_random();
        kind = 4'(next_random() % 12);
        case (kind)
            4'd0, 4'd1: begin
                ins[6:0]   = `OPC_OP;
                ins[31:25] = `F7_BASE;
                if ((ins[14:12] == `F3_ADD_SUB || ins[14:12] == `F3_SR) && ins[20])
                    ins[31:25] = `F7_ALT;
            end
            4'd2, 4'd3: begin
                ins[6:0] = `OPC_OP_IMM;
                if (ins[14:12] == `F3_SLL)
                    ins[31:25] = `F7_BASE;
                if (ins[14:12] == `F3_SR)
                    ins[31:25] = ins[20] ? `F7_ALT : `F7_BASE;
            end
            4'd4: ins[6:0] = `OPC_LUI;
            4'd5: ins[6:0] = `OPC_AUIPC;
            4'd6: ins[6:0] = `OPC_LOAD;
            4'd7: ins[6:0] = `OPC_STORE;
            4'd8: begin
                ins[6:0] = `OPC_BRANCH;
                if (ins[14:13] == 2'b01)
                    ins[13] = 1'b0; // 010 and 011 are no branch conditions.
            end
            4'd9: begin
                ins[6:0]   = ins[7] ? `OPC_JAL : `OPC_JALR;
                ins[14:12] = 3'b000;
            end
            4'd10: begin
                while (ins[6:0] inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_BRANCH,
                                        `OPC_LOAD, `OPC_STORE, `OPC_OP_IMM, `OPC_OP}) begin
                    r        = next_random();
                    ins[6:0] = r[6:0];
                end
            end
            default: begin
                if (ins[21]) begin
                    // shift immediates also reject a funct7 outside base and alternate.
                    ins[6:0]   = `OPC_OP_IMM;
                    ins[14:12] = ins[14] ? `F3_SR : `F3_SLL;
                end else begin
                    ins[6:0] = `OPC_OP;
                end
                if (ins[31:25] == `F7_BASE || ins[31:25] == `F7_ALT)
                    ins[31:25] = 7'b0000001;
            end
        endcase
        return ins;
    endfunction

    task automatic drive_next();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] a;
        r = next_random();
        // a stalled instruction stays on the inputs until it is taken.
        if (!stall) begin
            addr      = next_random();
            a         = next_random();
            in_valid  <= r[1:0] != 2'b00;
            instr     <= make_instruction();
            pc        <= {addr[31:2], 2'b00};
            rs1_value <= a;
            rs2_value <= (r[14:12] == 3'd0) ? a : next_random(); // equal operands for beq.
        end
        stall <= r[7:4] < 4'd3;
        flush <= r[11:8] == 4'd0;
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input logic [31:0] care);
        if ((actual & care) !== (expected & care)) begin
            value_errors++;
            $display("Fail at %0t: %s expected %h actual %h", $time, name,
                     expected & care, actual);
        end
    endtask

    task automatic check_result(input ex_result_t expected, input ex_result_t care,
                                input ex_result_t actual);
        checks++;
        check_field("result", expected.result, actual.result, care.result);
        check_field("addr_sum", expected.addr_sum, actual.addr_sum, care.addr_sum);
        check_field("branch_taken", 32'(expected.branch_taken), 32'(actual.branch_taken),
                    32'(care.branch_taken));
        check_field("branch_target", expected.branch_target, actual.branch_target,
                    care.branch_target);
        check_field("rd", 32'(expected.rd), 32'(actual.rd), 32'(care.rd));
        check_field("reg_write", 32'(expected.reg_write), 32'(actual.reg_write),
                    32'(care.reg_write));
        check_field("is_mem", 32'(expected.is_mem), 32'(actual.is_mem), 32'(care.is_mem));
        check_field("illegal", 32'(expected.illegal), 32'(actual.illegal), 32'(care.illegal));
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            valid_errors++;
            $display("Fail at %0t: out_valid expected %b actual %b", $time, expected, actual);
        end
    endtask

    // reference pipeline, it samples the same inputs the DUT sees on this edge.
    always @(posedge clk) begin
        stage_t entry;
        entry = '0;
        if (reset) begin
            pipe_q.delete();
            pipe_q.push_back(entry);
            pipe_q.push_back(entry);
        end else if (!stall) begin
            entry.valid = in_valid && !flush;
            predict_result(instr, pc, rs1_value, rs2_value, entry.expected, entry.care);
            void'(pipe_q.pop_back());
            pipe_q.push_front(entry);
        end
    end

    always @(negedge clk) begin
        if (pipe_q.size() == 2) begin
            check_valid(pipe_q[1].valid, out_valid);
            if (pipe_q[1].valid && out_valid === 1'b1)
                check_result(pipe_q[1].expected, pipe_q[1].care, out);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        reset     <= 1'b1;
        in_valid  <= 1'b0;
        instr     <= '0;
        pc        <= '0;
        rs1_value <= '0;
        rs2_value <= '0;
        stall     <= 1'b0;
        flush     <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < num_cycles; i++) begin
            @(posedge clk);
            drive_next();
        end
        @(posedge clk);
        in_valid <= 1'b0;
        stall    <= 1'b0;
        flush    <= 1'b0;
        do
            @(negedge clk);
        while (pipe_q[0].valid || pipe_q[1].valid);
        #1;
        $display("errors: %0d value, %0d valid, over %0d compared results",
                 value_errors, valid_errors, checks);
        if (value_errors == 0 && valid_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
source/rv32_pkg.sv
source/alu_decoder.sv
source/pipe_reg.sv
source/alu.sv
source/branch_unit.sv
source/exec_unit.sv
verification/exec_unit_tb.sv

/* Makefile */
SOURCES := $(wildcard include/*.svh source/*.sv verification/*.sv)

.PHONY: all run clean

all: obj_dir/Vexec_unit_tb

# rebuilt only when the file list or a source changes.
obj_dir/Vexec_unit_tb: src.f $(SOURCES)
	verilator --binary --timing --assert -f src.f --top-module exec_unit_tb

# the run passes only when the pass message shows up in the output.
run: obj_dir/Vexec_unit_tb
	@out="$$(./obj_dir/Vexec_unit_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
